/* bpu_predictor.f */
source/bpu_cfg_pkg.sv
source/rv_isa_pkg.sv
source/tagged_table.sv
source/tage_direction.sv
source/btb.sv
source/target_select.sv
source/bpu_top.sv
dv/bpu_tb_pkg.sv
dv/bpu_tb.sv

/* Bender.yml */
package:
  name: bpu_predictor

sources:
  - source/bpu_cfg_pkg.sv
  - source/rv_isa_pkg.sv
  - source/tagged_table.sv
  - source/tage_direction.sv
  - source/btb.sv
  - source/target_select.sv
  - source/bpu_top.sv
  - target: simulation
    files:
      - dv/bpu_tb_pkg.sv
      - dv/bpu_tb.sv

/* dv/bpu_tb.sv */
`timescale 1ns/100ps

module bpu_tb
    import bpu_cfg_pkg::*;
    import bpu_tb_pkg::*;
();

    localparam int reset_cycles   = 16;
    localparam int timeout_cycles = stim_len + reset_cycles + 20;

    logic    clk;
    logic    rst;
    fetch_t  fetch;
    update_t update;
    pred_t   pred;

    pred_t   seen_pred [stim_len];    // predictions kept for the echoed updates
    ghist_t  hist_model;
    int      cycle_count = 0;

    bpu_top bpu_top_inst (
        .clk      (clk),
        .rst      (rst),
        .fetch_i  (fetch),
        .update_i (update),
        .pred_o   (pred)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("the run did not finish within %0d cycles", timeout_cycles);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    task automatic check_flag(string what, logic actual, logic expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_addr(string what, addr_t actual, addr_t expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_history(string what, ghist_t actual, ghist_t expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "history mismatch");
        end
    endtask

    task automatic check_provider(string what, provider_e actual, provider_e expected);
        if (actual !== expected) begin
            $display("ERR %0t: %s is %s, expected %s", $time, what, actual.name(),
                     expected.name());
            $display("Finished with errors");
            $fatal(1, "provider mismatch");
        end
    endtask

    // execute side: resolved outcome plus what the fetch stage predicted
    function automatic update_t echo_update(stim_row_t row);
        update_t u;
        pred_t   src;
        u = '0;
        if (row.upd_valid) begin
            src        = seen_pred[row.upd_src];
            u.valid    = 1'b1;
            u.taken    = row.upd_taken;
            u.correct  = (src.taken == row.upd_taken);
            u.pc       = stim_table[row.upd_src].pc;
            u.target   = row.upd_target;
            u.provider = src.provider;
            u.history  = src.history;
        end
        return u;
    endfunction

    task automatic check_row(int r);
        stim_row_t row;
        row = stim_table[r];
        check_flag($sformatf("row %0d is_cf", r), pred.is_cf, row.exp_cf);
        check_flag($sformatf("row %0d taken", r), pred.taken, row.exp_taken);
        check_addr($sformatf("row %0d next pc", r), pred.pc, row.exp_pc);
        check_history($sformatf("row %0d history", r), pred.history, hist_model);
        if (row.chk_prov) begin
            check_provider($sformatf("row %0d provider", r), pred.provider, row.exp_prov);
        end
        seen_pred[r] = pred;
        if (row.upd_valid) begin
            hist_model = {hist_model[ghist_len-2:0], row.upd_taken};    // dut shifts next edge
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        fetch      = '0;
        update     = '0;
        hist_model = '0;
        build_stim_table();
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < stim_len; r++) begin
            @(posedge clk);
            fetch.pc   <= stim_table[r].pc;
            fetch.inst <= stim_table[r].inst;
            update     <= echo_update(stim_table[r]);
            @(negedge clk);    // combinational outputs settled
            check_row(r);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* dv/bpu_tb_pkg.sv */
package bpu_tb_pkg;
    import bpu_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam logic [31:0] lfsr_seed = 32'h9d631f1a;
    localparam int          stim_len  = 37;

    localparam addr_t pc_b = 32'h0000_1040;    // branch that ends up in the long table
    localparam addr_t pc_f = 32'h0002_0200;    // filler branch, pc bit 17 keeps its tag apart
    localparam addr_t pc_j = 32'h0000_3100;
    localparam addr_t pc_r = 32'h0000_3200;    // return site
    localparam logic [12:0] b_offset    = 13'h0080;
    localparam logic [12:0] f_offset    = 13'h1ff8;
    localparam logic [20:0] j_offset    = 21'h00400;
    localparam addr_t       jal_trained = 32'h0000_5000;

    typedef struct packed {
        addr_t      pc;
        inst_t      inst;
        logic       upd_valid;
        logic [7:0] upd_src;       // row whose prediction is echoed back
        logic       upd_taken;
        addr_t      upd_target;
        logic       exp_cf;
        logic       exp_taken;
        addr_t      exp_pc;
        logic       chk_prov;
        provider_e  exp_prov;
    } stim_row_t;

    stim_row_t   stim_table [stim_len];
    logic [31:0] lfsr_state = lfsr_seed;

    // taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // bne t0, x0
    function automatic inst_t make_branch(logic [12:0] imm);
        return {imm[12], imm[10:5], reg_zero, reg_t0, 3'b001, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic inst_t make_jal(reg_idx_t rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic inst_t make_jalr(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op_jalr};
    endfunction

    // random word with an opcode that is never control flow
    function automatic inst_t make_plain();
        inst_t   word;
        opcode_t opc;
        word = rand_bits(32);
        case (rand_bits(2))
            0:       opc = op_op;
            1:       opc = op_op_imm;
            2:       opc = op_load;
            default: opc = op_lui;
        endcase
        return {word[31:7], opc};
    endfunction

    function automatic void fetch_row(int r, addr_t pc, inst_t inst, logic cf, logic taken,
                                      addr_t next_pc);
        stim_table[r]           = '0;
        stim_table[r].pc        = pc;
        stim_table[r].inst      = inst;
        stim_table[r].exp_cf    = cf;
        stim_table[r].exp_taken = taken;
        stim_table[r].exp_pc    = next_pc;
    endfunction

    function automatic void random_row(int r);
        addr_t pc;
        inst_t inst;
        pc   = rand_bits(32) & 32'hffff_fffc;
        inst = make_plain();
        fetch_row(r, pc, inst, 1'b0, 1'b0, pc + 32'd4);
    endfunction

    function automatic void expect_provider(int r, provider_e p);
        stim_table[r].chk_prov = 1'b1;
        stim_table[r].exp_prov = p;
    endfunction

    function automatic void add_update(int r, int src, logic taken, addr_t target);
        stim_table[r].upd_valid  = 1'b1;
        stim_table[r].upd_src    = 8'(src);
        stim_table[r].upd_taken  = taken;
        stim_table[r].upd_target = target;
    endfunction

    function automatic void build_stim_table();
        for (int r = 0; r < 6; r++) begin
            random_row(r);
        end
        fetch_row(6, pc_b, make_branch(b_offset), 1'b1, 1'b0, pc_b + 32'd4);
        expect_provider(6, prov_bimodal);
        random_row(7);
        add_update(7, 6, 1'b1, pc_b + addr_t'(b_offset));    // mispredict, long allocates
        // sixteen not-taken updates bring the history back to zero
        for (int r = 8; r < 24; r++) begin
            fetch_row(r, pc_f, make_branch(f_offset), 1'b1, 1'b0, pc_f + 32'd4);
            expect_provider(r, prov_bimodal);
            if (r > 8) begin
                add_update(r, r - 1, 1'b0, pc_f + 32'd4);
            end
        end
        random_row(24);
        add_update(24, 23, 1'b0, pc_f + 32'd4);
        fetch_row(25, pc_b, make_branch(b_offset), 1'b1, 1'b1, pc_b + addr_t'(b_offset));
        expect_provider(25, prov_long);
        random_row(26);
        add_update(26, 25, 1'b0, pc_b + 32'd4);                // long provider was wrong
        fetch_row(27, pc_b, make_branch(b_offset), 1'b1, 1'b0, pc_b + 32'd4);
        expect_provider(27, prov_long);
        fetch_row(28, pc_j, make_jal(reg_ra, j_offset), 1'b1, 1'b1, pc_j + addr_t'(j_offset));
        random_row(29);
        add_update(29, 28, 1'b1, jal_trained);
        fetch_row(30, pc_j, make_jal(reg_ra, j_offset), 1'b1, 1'b1, jal_trained);
        fetch_row(31, pc_r, make_jalr(reg_zero, reg_ra, 12'h000), 1'b1, 1'b0, pc_r + 32'd4);
        fetch_row(32, pc_f, make_branch(f_offset), 1'b1, 1'b0, pc_f + 32'd4);
        expect_provider(32, prov_bimodal);
        add_update(32, 30, 1'b1, jal_trained);
        fetch_row(33, pc_j, make_jal(reg_ra, j_offset), 1'b1, 1'b1, jal_trained);
        add_update(33, 32, 1'b0, pc_f + 32'd4);
        fetch_row(34, pc_j, make_jal(reg_ra, j_offset), 1'b1, 1'b1, jal_trained);
        add_update(34, 33, 1'b1, jal_trained);
        random_row(35);
        add_update(35, 34, 1'b1, jal_trained);
        random_row(36);
    endfunction

endpackage

/* source/bpu_top.sv */
`timescale 1ns/100ps

module bpu_top
    import bpu_cfg_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  fetch_t  fetch_i,
    input  update_t update_i,
    output pred_t   pred_o
);

    logic      dir_taken;
    provider_e provider;
    ghist_t    history;
    logic      btb_hit;
    addr_t     btb_target;

    // direction from bimodal and the two tagged tables
    tage_direction tage_direction_inst (
        .clk        (clk),
        .rst        (rst),
        .pc_i       (fetch_i.pc),
        .update_i   (update_i),
        .taken_o    (dir_taken),
        .provider_o (provider),
        .history_o  (history)
    );

    btb btb_inst (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (fetch_i.pc),
        .update_i (update_i),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    // predecode and next pc
    target_select target_select_inst (
        .fetch_i      (fetch_i),
        .dir_taken_i  (dir_taken),
        .provider_i   (provider),
        .history_i    (history),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .pred_o       (pred_o)
    );

endmodule

/* source/target_select.sv */
`timescale 1ns/100ps

module target_select
    import bpu_cfg_pkg::*;
    import rv_isa_pkg::*;
(
    input  fetch_t    fetch_i,
    input  logic      dir_taken_i,
    input  provider_e provider_i,
    input  ghist_t    history_i,
    input  logic      btb_hit_i,
    input  addr_t     btb_target_i,
    output pred_t     pred_o
);

    inst_t   inst;
    opcode_t opcode;
    logic    is_branch;
    logic    is_jal;
    logic    is_jalr;
    logic    taken;
    addr_t   imm_b;
    addr_t   imm_j;
    addr_t   fallthrough;
    addr_t   decoded_target;

    assign inst   = fetch_i.inst;
    assign opcode = inst[opc_msb:opc_lsb];

    assign is_branch = (opcode == op_branch);
    assign is_jal    = (opcode == op_jal);
    assign is_jalr   = (opcode == op_jalr);    // no return stack, always falls through

    // sign extended offsets
    assign imm_b = {{(xlen-imm_b_len){inst[imm_sign_bit]}}, inst[imm_sign_bit], inst[7],
                    inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{(xlen-imm_j_len){inst[imm_sign_bit]}}, inst[imm_sign_bit],
                    inst[19:12], inst[20], inst[30:21], 1'b0};

    assign fallthrough    = fetch_i.pc + addr_t'(4);
    assign decoded_target = fetch_i.pc + (is_jal ? imm_j : imm_b);

    always_comb begin
        taken = 1'b0;
        if (is_branch) begin
            taken = dir_taken_i;
        end else if (is_jal) begin
            taken = 1'b1;
        end
    end

    always_comb begin
        pred_o.is_cf = is_branch || is_jal || is_jalr;
        pred_o.taken = taken;
        if (!taken) begin
            pred_o.pc = fallthrough;
        end else if (btb_hit_i) begin
            pred_o.pc = btb_target_i;    // trained target beats the decoded one
        end else begin
            pred_o.pc = decoded_target;
        end
        // echoed back with the update
        pred_o.provider = provider_i;
        pred_o.history  = history_i;
    end

endmodule

/* source/btb.sv */
`timescale 1ns/100ps

module btb
    import bpu_cfg_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  addr_t   pc_i,
    input  update_t update_i,
    output logic    hit_o,
    output addr_t   target_o
);

    btb_tag_t target_tag [btb_entries];
    addr_t    target_mem [btb_entries];
    logic [btb_entries-1:0] valid_q;

    btb_index_t lookup_index;
    btb_tag_t   lookup_tag;
    btb_index_t upd_index;
    btb_tag_t   upd_tag;
    logic       write_en;

    // word aligned index, upper pc bits as tag
    assign lookup_index = pc_i[btb_index_len+1:2];
    assign lookup_tag   = pc_i[xlen-1 -: btb_tag_len];
    assign upd_index    = update_i.pc[btb_index_len+1:2];
    assign upd_tag      = update_i.pc[xlen-1 -: btb_tag_len];

    assign write_en = update_i.valid && update_i.taken;    // only taken branches fill

    assign hit_o    = valid_q[lookup_index] && (target_tag[lookup_index] == lookup_tag);
    assign target_o = target_mem[lookup_index];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (write_en) begin
            valid_q[upd_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            target_tag[upd_index] <= upd_tag;
            target_mem[upd_index] <= update_i.target;
        end
    end

    // targets from execute are at least halfword aligned
    a_target_aligned : assert property (
        @(posedge clk) disable iff (rst)
        update_i.valid |-> !update_i.target[0]
    );

endmodule

/* source/tage_direction.sv */
`timescale 1ns/100ps

module tage_direction
    import bpu_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  addr_t     pc_i,
    input  update_t   update_i,
    output logic      taken_o,
    output provider_e provider_o,
    output ghist_t    history_o
);

    ghist_t    ghist_q;
    ctr_t      bm_mem [bimodal_entries];

    bm_index_t lookup_bm_index;
    bm_index_t upd_bm_index;

    tt_index_t short_lookup_index, long_lookup_index;
    tt_tag_t   short_lookup_tag, long_lookup_tag;
    tt_index_t short_upd_index, long_upd_index;
    tt_tag_t   short_upd_tag, long_upd_tag;

    logic      short_match, long_match;
    ctr_t      short_ctr, long_ctr;
    logic      short_tag_hit, long_tag_hit;

    logic      short_train, long_train;
    logic      short_reset, long_reset;
    logic      short_alloc, long_alloc;

    provider_e provider;

    function automatic tt_index_t short_index(addr_t pc, ghist_t h);
        return pc[tt_index_len-1:0] ^ h[tt_index_len-1:0];
    endfunction

    function automatic tt_tag_t short_tag(addr_t pc, ghist_t h);
        return pc[tt_index_len +: tag_len] ^ h[ghist_len-1 -: tag_len];
    endfunction

    function automatic tt_index_t long_index(addr_t pc, ghist_t h);
        return pc[tt_index_len-1:0] ^ h[ghist_len-1 -: tt_index_len];
    endfunction

    function automatic tt_tag_t long_tag(addr_t pc, ghist_t h);
        return pc[tt_index_len +: tag_len] ^ tt_tag_t'(h[tt_index_len-1:0]);
    endfunction

    assign history_o = ghist_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist_q <= '0;
        end else if (update_i.valid) begin
            ghist_q <= {ghist_q[ghist_len-2:0], update_i.taken};
        end
    end

    assign lookup_bm_index = pc_i[bm_index_len:1];
    assign upd_bm_index    = update_i.pc[bm_index_len:1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bimodal_entries; i++) begin
                bm_mem[i] <= ctr_weak_nt;
            end
        end else if (update_i.valid) begin
            bm_mem[upd_bm_index] <= ctr_train(bm_mem[upd_bm_index], update_i.taken);
        end
    end

    // lookups fold the live history
    assign short_lookup_index = short_index(pc_i, ghist_q);
    assign short_lookup_tag   = short_tag(pc_i, ghist_q);
    assign long_lookup_index  = long_index(pc_i, ghist_q);
    assign long_lookup_tag    = long_tag(pc_i, ghist_q);

    // updates fold the snapshot echoed back from execute
    assign short_upd_index = short_index(update_i.pc, update_i.history);
    assign short_upd_tag   = short_tag(update_i.pc, update_i.history);
    assign long_upd_index  = long_index(update_i.pc, update_i.history);
    assign long_upd_tag    = long_tag(update_i.pc, update_i.history);

    // longest matching history wins
    assign provider = long_match  ? prov_long  :
                      short_match ? prov_short : prov_bimodal;
    assign provider_o = provider;

    always_comb begin
        case (provider)
            prov_long:  taken_o = long_ctr[1];
            prov_short: taken_o = short_ctr[1];
            default:    taken_o = bm_mem[lookup_bm_index][1];
        endcase
    end

    always_comb begin
        short_train = 1'b0;
        long_train  = 1'b0;
        short_reset = 1'b0;
        long_reset  = 1'b0;
        short_alloc = 1'b0;
        long_alloc  = 1'b0;
        if (update_i.valid) begin
            if (update_i.correct) begin
                short_train = (update_i.provider == prov_short);
                long_train  = (update_i.provider == prov_long);
            end else begin
                case (update_i.provider)
                    prov_long:  long_reset  = 1'b1;
                    prov_short: short_reset = 1'b1;
                    prov_bimodal: begin
                        // prefer the long table, fall back to short
                        if (!long_tag_hit) begin
                            long_alloc = 1'b1;
                        end else if (!short_tag_hit) begin
                            short_alloc = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    tagged_table short_table (
        .clk            (clk),
        .rst            (rst),
        .lookup_index_i (short_lookup_index),
        .lookup_tag_i   (short_lookup_tag),
        .match_o        (short_match),
        .ctr_o          (short_ctr),
        .upd_index_i    (short_upd_index),
        .upd_tag_i      (short_upd_tag),
        .train_i        (short_train),
        .alloc_i        (short_alloc),
        .reset_ctr_i    (short_reset),
        .taken_i        (update_i.taken),
        .tag_hit_o      (short_tag_hit)
    );

    tagged_table long_table (
        .clk            (clk),
        .rst            (rst),
        .lookup_index_i (long_lookup_index),
        .lookup_tag_i   (long_lookup_tag),
        .match_o        (long_match),
        .ctr_o          (long_ctr),
        .upd_index_i    (long_upd_index),
        .upd_tag_i      (long_upd_tag),
        .train_i        (long_train),
        .alloc_i        (long_alloc),
        .reset_ctr_i    (long_reset),
        .taken_i        (update_i.taken),
        .tag_hit_o      (long_tag_hit)
    );

    // provider comes back from the prediction, so it must be a legal value
    a_upd_provider_known : assert property (
        @(posedge clk) disable iff (rst)
        update_i.valid |-> !$isunknown(update_i.provider) &&
                           (update_i.provider inside {prov_bimodal, prov_short, prov_long})
    );

endmodule

/* source/tagged_table.sv */
`timescale 1ns/100ps

module tagged_table
    import bpu_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  tt_index_t lookup_index_i,
    input  tt_tag_t   lookup_tag_i,
    output logic      match_o,
    output ctr_t      ctr_o,

    input  tt_index_t upd_index_i,
    input  tt_tag_t   upd_tag_i,
    input  logic      train_i,
    input  logic      alloc_i,
    input  logic      reset_ctr_i,
    input  logic      taken_i,
    output logic      tag_hit_o
);

    tt_tag_t             tag_mem [tagged_entries];
    ctr_t                ctr_mem [tagged_entries];
    logic [tagged_entries-1:0] valid_q;

    tt_tag_t stored_tag;

    assign stored_tag = tag_mem[lookup_index_i];

    // lookup only compares the upper part of the tag
    assign match_o = valid_q[lookup_index_i] &&
                     (stored_tag[tag_len-1 -: partial_tag_bits] ==
                      lookup_tag_i[tag_len-1 -: partial_tag_bits]);
    assign ctr_o   = ctr_mem[lookup_index_i];

    // full compare for the allocation decision
    assign tag_hit_o = valid_q[upd_index_i] && (tag_mem[upd_index_i] == upd_tag_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;    // empty table never matches
        end else if (alloc_i) begin
            valid_q[upd_index_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            tag_mem[upd_index_i] <= upd_tag_i;
            ctr_mem[upd_index_i] <= taken_i ? ctr_weak_t : ctr_weak_nt;
        end else if (reset_ctr_i) begin
            // wrong provider jumps straight to strong
            ctr_mem[upd_index_i] <= taken_i ? ctr_strong_t : ctr_strong_nt;
        end else if (train_i) begin
            ctr_mem[upd_index_i] <= ctr_train(ctr_mem[upd_index_i], taken_i);
        end
    end

    // one entry is either replaced or trained in a cycle, not both
    a_alloc_not_train : assert property (
        @(posedge clk) disable iff (rst)
        !(alloc_i && train_i)
    );

endmodule

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_op_imm = 7'b0010011;
    localparam opcode_t op_auipc  = 7'b0010111;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_op     = 7'b0110011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_jal    = 7'b1101111;

    localparam reg_idx_t reg_zero = 5'd0;
    localparam reg_idx_t reg_ra   = 5'd1;    // link register
    localparam reg_idx_t reg_t0   = 5'd5;    // alternate link

    // field positions in the instruction word
    localparam int opc_lsb      = 0;
    localparam int opc_msb      = 6;
    localparam int rd_lsb       = 7;
    localparam int funct3_lsb   = 12;
    localparam int rs1_lsb      = 15;
    localparam int rs2_lsb      = 20;
    localparam int imm_sign_bit = 31;

    // immediate widths including the implied zero lsb
    localparam int imm_b_len = 13;
    localparam int imm_j_len = 21;

endpackage

/* source/bpu_cfg_pkg.sv */
package bpu_cfg_pkg;

    localparam int xlen             = 32;
    localparam int ghist_len        = 16;
    localparam int bimodal_entries  = 512;
    localparam int bm_index_len     = $clog2(bimodal_entries);
    localparam int tagged_entries   = 256;
    localparam int tt_index_len     = $clog2(tagged_entries);
    localparam int tag_len          = 10;
    localparam int partial_tag_bits = 6;    // upper tag bits used for a lookup match
    localparam int btb_entries      = 256;
    localparam int btb_index_len    = $clog2(btb_entries);
    localparam int btb_tag_len      = 22;

    typedef logic [xlen-1:0]          addr_t;
    typedef logic [ghist_len-1:0]     ghist_t;
    typedef logic [bm_index_len-1:0]  bm_index_t;
    typedef logic [tt_index_len-1:0]  tt_index_t;
    typedef logic [tag_len-1:0]       tt_tag_t;
    typedef logic [btb_index_len-1:0] btb_index_t;
    typedef logic [btb_tag_len-1:0]   btb_tag_t;
    typedef logic [1:0]               ctr_t;

    // 2-bit counter states, msb is the predicted direction
    localparam ctr_t ctr_strong_nt = 2'b00;
    localparam ctr_t ctr_weak_nt   = 2'b01;
    localparam ctr_t ctr_weak_t    = 2'b10;
    localparam ctr_t ctr_strong_t  = 2'b11;

    typedef enum logic [1:0] {
        prov_bimodal = 2'd0,
        prov_short   = 2'd1,
        prov_long    = 2'd2
    } provider_e;

    typedef struct packed {
        addr_t           pc;
        logic [xlen-1:0] inst;
    } fetch_t;

    typedef struct packed {
        logic      is_cf;
        logic      taken;
        addr_t     pc;
        provider_e provider;
        ghist_t    history;    // history the lookup was folded with
    } pred_t;

    typedef struct packed {
        logic      valid;
        logic      taken;
        logic      correct;
        addr_t     pc;
        addr_t     target;
        provider_e provider;
        ghist_t    history;
    } update_t;

    // saturating step toward the resolved direction
    function automatic ctr_t ctr_train(ctr_t ctr, logic taken);
        if (taken) begin
            return (ctr == ctr_strong_t) ? ctr : ctr + ctr_t'(1);
        end
        return (ctr == ctr_strong_nt) ? ctr : ctr - ctr_t'(1);
    endfunction

endpackage
